/* list.f */
+incdir+test
logic/core_pkg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/mem_stage.sv
logic/core_top.sv
test/core_tb.sv

/* test/core_program.svh */
`ifndef CORE_PROGRAM_SVH
`define CORE_PROGRAM_SVH

localparam int LUI    = 'h37;
localparam int AUIPC  = 'h17;
localparam int JAL    = 'h6f;
localparam int JALR   = 'h67;
localparam int LOAD   = 'h03;
localparam int OP_IMM = 'h13;
localparam int OP     = 'h33;
localparam int FENCE  = 'h0f;

logic [31:0] prog_pc; // Address of the next instruction placed

// ######################################
// RV32I instruction formats
// ######################################

function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                       input int f3, input int rd);
  return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                       input int rd, input int opc);
  return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
endfunction

function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1,
                                       input int f3);
  return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                       input int f3);
  return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] u_type(input int imm, input int rd, input int opc);
  return {imm[19:0], rd[4:0], opc[6:0]};
endfunction

function automatic logic [31:0] j_type(input int imm, input int rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

// Opcodes that write rd
function automatic logic writes_rd(input logic [31:0] inst);
  case (inst[6:0])
    LUI, AUIPC, JAL, JALR, LOAD, OP_IMM, OP: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

// Places one instruction and the retirement it should produce
task automatic add_transfer(input string name, input logic [31:0] inst, input int rd,
                            input logic [31:0] data, input logic [31:0] next_pc,
                            input logic illegal);
  retire_exp_t e;
  imem[prog_pc[9:2]] = inst;
  e.name    = name;
  e.pc      = prog_pc;
  e.next_pc = next_pc;
  e.rd      = rd[4:0];
  e.data    = data;
  e.rwen    = writes_rd(inst);
  e.illegal = illegal;
  expected.push_back(e);
  prog_pc = next_pc; // Skipped slots keep the illegal fill
endtask

task automatic seq_inst(input string name, input logic [31:0] inst, input int rd,
                        input logic [31:0] data);
  add_transfer(name, inst, rd, data, prog_pc + 32'd4, 1'b0);
endtask

`endif

/* test/core_tb.sv */
`default_nettype none

module core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct {
    string       name;
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        rwen;
    logic        illegal;
  } retire_exp_t;

  logic              clk;
  logic              rst;
  logic [31:0]       imem_addr;
  logic [31:0]       imem_data;
  logic              retire_valid;
  core_pkg::retire_t retire;
  logic              halted;

  logic [31:0]       imem [256];
  retire_exp_t       expected [$];
  int                errors;
  int                passed;
  int                cycle_count;
  int                cycle_limit;

  `include "core_program.svh"

  core_top #(
    .RESET_PC   (32'h0000_0000),
    .DMEM_WORDS (256)
  ) u_core_top (
    .clk            (clk),
    .rst            (rst),
    .imem_addr_o    (imem_addr),
    .imem_data_i    (imem_data),
    .retire_valid_o (retire_valid),
    .retire_o       (retire),
    .halted_o       (halted)
  );

  assign imem_data = imem[imem_addr[9:2]]; // Combinational fetch

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ######################################
  // Program and expected retirements
  // ######################################

  task automatic build_program();
    logic [31:0] link;
    prog_pc = 32'h0000_0000;
    seq_inst("addi x1", i_type(100, 0, 0, 1, OP_IMM), 1, 32'h0000_0064);
    seq_inst("addi x2 negative", i_type(-7, 0, 0, 2, OP_IMM), 2, 32'hffff_fff9);
    seq_inst("add", r_type(0, 2, 1, 0, 3), 3, 32'h0000_005d);
    seq_inst("sub", r_type('h20, 1, 2, 0, 4), 4, 32'hffff_ff95);
    seq_inst("slli", i_type(4, 1, 1, 5, OP_IMM), 5, 32'h0000_0640);
    seq_inst("srli", i_type(28, 2, 5, 6, OP_IMM), 6, 32'h0000_000f);
    seq_inst("srai negative", i_type('h401, 2, 5, 7, OP_IMM), 7, 32'hffff_fffc);
    seq_inst("sra negative", r_type('h20, 6, 4, 5, 8), 8, 32'hffff_ffff);
    seq_inst("srl", r_type(0, 6, 4, 5, 9), 9, 32'h0001_ffff);
    seq_inst("sll", r_type(0, 6, 1, 1, 10), 10, 32'h0032_0000);
    seq_inst("slt", r_type(0, 1, 2, 2, 11), 11, 32'h0000_0001);
    seq_inst("sltu", r_type(0, 1, 2, 3, 12), 12, 32'h0000_0000);
    seq_inst("slti", i_type(-6, 2, 2, 13, OP_IMM), 13, 32'h0000_0001);
    seq_inst("sltiu", i_type(5, 2, 3, 14, OP_IMM), 14, 32'h0000_0000);
    seq_inst("xori", i_type('hff, 1, 4, 15, OP_IMM), 15, 32'h0000_009b);
    seq_inst("or", r_type(0, 2, 1, 6, 16), 16, 32'hffff_fffd);
    seq_inst("and", r_type(0, 2, 1, 7, 17), 17, 32'h0000_0060);
    seq_inst("andi", i_type('hf0, 2, 7, 18, OP_IMM), 18, 32'h0000_00f0);
    seq_inst("xor", r_type(0, 4, 1, 4, 19), 19, 32'hffff_fff1);
    seq_inst("ori", i_type('h1b, 1, 6, 20, OP_IMM), 20, 32'h0000_007f);
    seq_inst("lui", u_type('h12345, 21, LUI), 21, 32'h1234_5000);
    seq_inst("auipc", u_type(1, 22, AUIPC), 22, prog_pc + 32'h0000_1000);
    // Branches and jumps
    add_transfer("beq taken", b_type(8, 1, 1, 0), 0, 0, prog_pc + 32'd8, 1'b0);
    seq_inst("bne not taken", b_type(8, 1, 1, 1), 0, 0);
    add_transfer("blt taken", b_type(12, 1, 2, 4), 0, 0, prog_pc + 32'd12, 1'b0);
    add_transfer("bgeu taken", b_type(8, 1, 2, 7), 0, 0, prog_pc + 32'd8, 1'b0);
    seq_inst("bge not taken", b_type(8, 1, 2, 5), 0, 0);
    link = prog_pc + 32'd4;
    add_transfer("jal", j_type(16, 23), 23, link, prog_pc + 32'd16, 1'b0);
    add_transfer("jalr odd target", i_type('h15, 23, 0, 24, JALR), 24, prog_pc + 32'd4,
                 link + 32'h14, 1'b0); // Odd sum 0x15 loses bit 0
    // Data RAM at 0x100
    seq_inst("base address", i_type(256, 0, 0, 25, OP_IMM), 25, 32'h0000_0100);
    seq_inst("lui data", u_type('h89abd, 26, LUI), 26, 32'h89ab_d000);
    seq_inst("addi data", i_type(-529, 26, 0, 26, OP_IMM), 26, 32'h89ab_cdef);
    seq_inst("sw", s_type(0, 26, 25, 2), 0, 0);
    seq_inst("lw after sw", i_type(0, 25, 2, 27, LOAD), 27, 32'h89ab_cdef);
    seq_inst("lh after sw", i_type(2, 25, 1, 28, LOAD), 28, 32'hffff_89ab);
    seq_inst("lhu after sw", i_type(0, 25, 5, 29, LOAD), 29, 32'h0000_cdef);
    seq_inst("lb after sw", i_type(1, 25, 0, 30, LOAD), 30, 32'hffff_ffcd);
    seq_inst("lbu after sw", i_type(3, 25, 4, 31, LOAD), 31, 32'h0000_0089);
    seq_inst("sh", s_type(2, 2, 25, 1), 0, 0);
    seq_inst("lw after sh", i_type(0, 25, 2, 27, LOAD), 27, 32'hfff9_cdef);
    seq_inst("lh after sh", i_type(2, 25, 1, 28, LOAD), 28, 32'hffff_fff9);
    seq_inst("lhu after sh", i_type(2, 25, 5, 29, LOAD), 29, 32'h0000_fff9);
    seq_inst("lb after sh", i_type(3, 25, 0, 30, LOAD), 30, 32'hffff_ffff);
    seq_inst("lbu after sh", i_type(2, 25, 4, 31, LOAD), 31, 32'h0000_00f9);
    seq_inst("sb", s_type(1, 1, 25, 0), 0, 0);
    seq_inst("lw after sb", i_type(0, 25, 2, 27, LOAD), 27, 32'hfff9_64ef);
    seq_inst("lh after sb", i_type(0, 25, 1, 28, LOAD), 28, 32'h0000_64ef);
    seq_inst("lhu after sb", i_type(0, 25, 5, 29, LOAD), 29, 32'h0000_64ef);
    seq_inst("lb after sb", i_type(0, 25, 0, 30, LOAD), 30, 32'hffff_ffef);
    seq_inst("lbu after sb", i_type(1, 25, 4, 31, LOAD), 31, 32'h0000_0064);
    // x0 keeps reading zero
    seq_inst("write x0", i_type(5, 1, 0, 0, OP_IMM), 0, 32'h0000_0069);
    seq_inst("read x0", r_type(0, 1, 0, 0, 5), 5, 32'h0000_0064);
    seq_inst("fence", i_type(0, 0, 0, 0, FENCE), 0, 0);
    add_transfer("illegal opcode", 32'h0000_0000, 0, 0, prog_pc + 32'd4, 1'b1);
  endtask

  task automatic fill_imem();
    for (int i = 0; i < 256; i++) begin
      imem[i] = {i[24:0], 7'b1111111}; // Opcode 7f is illegal
    end
  endtask

  // ######################################
  // Checking
  // ######################################

  task automatic wait_retire();
    do begin
      @(negedge clk);
    end while (!retire_valid);
  endtask

  task automatic compare_field(input string test, input string field,
                               input logic [31:0] exp_v, input logic [31:0] act_v,
                               inout logic ok);
    assert (act_v === exp_v) else begin
      $display("FAILED %s %s expected %h actual %h", test, field, exp_v, act_v);
      ok = 1'b0;
    end
  endtask

  task automatic tally(input string test, input logic ok);
    if (ok) begin
      passed++;
      $display("passed %s", test);
    end else begin
      errors++;
    end
  endtask

  task automatic score_entry(input retire_exp_t e);
    logic ok;
    ok = 1'b1;
    compare_field(e.name, "pc", e.pc, retire.pc, ok);
    compare_field(e.name, "next_pc", e.next_pc, retire.next_pc, ok);
    compare_field(e.name, "rd", 32'(e.rd), 32'(retire.rd), ok);
    compare_field(e.name, "data", e.data, retire.data, ok);
    compare_field(e.name, "rwen", 32'(e.rwen), 32'(retire.rwen), ok);
    compare_field(e.name, "illegal", 32'(e.illegal), 32'(retire.illegal), ok);
    tally(e.name, ok);
  endtask

  initial begin : watchdog
    @(posedge clk);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the core stopped retiring", cycle_count);
    $display("Done: errors found");
    $finish;
  end

  initial begin : main
    int   n;
    logic ok;
    rst         = 1'b1;
    errors      = 0;
    passed      = 0;
    cycle_count = 0;
    fill_imem();
    build_program();
    cycle_limit = expected.size() * 8 + 50;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    foreach (expected[i]) begin
      wait_retire();
      score_entry(expected[i]);
    end
    n = 0;
    while (!halted && n < 4) begin
      @(negedge clk);
      n++;
    end
    ok = 1'b1;
    assert (halted === 1'b1) else begin
      $display("FAILED halt expected 1 actual %b", halted);
      ok = 1'b0;
    end
    tally("halt", ok);
    n = 0;
    repeat (20) begin
      @(negedge clk);
      if (retire_valid) begin
        n++;
      end
    end
    ok = 1'b1;
    assert (n == 0) else begin
      $display("Core kept retiring after halt, %0d pulses in 20 cycles", n);
      ok = 1'b0;
    end
    tally("quiet after halt", ok);
    $display("Tests: %0d passed, %0d failed", passed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/core_top.sv */
`default_nettype none

module core_top #(
  parameter core_pkg::word_t RESET_PC   = 32'h0000_0000,
  parameter int              DMEM_WORDS = 256
) (
  input  logic              clk,
  input  logic              rst,
  output core_pkg::word_t   imem_addr_o,
  input  core_pkg::inst_t   imem_data_i,
  output logic              retire_valid_o,
  output core_pkg::retire_t retire_o,
  output logic              halted_o
);
  import core_pkg::*;

  // ######################################
  // Stage links
  // ######################################

  logic       f_valid;
  logic       f_ready;
  fetch_pkt_t f_pkt;
  logic       d_valid;
  logic       d_ready;
  dec_pkt_t   d_pkt;
  logic       x_valid;
  logic       x_ready;
  exe_pkt_t   x_pkt;

  reg_addr_t  rs1;
  reg_addr_t  rs2;
  word_t      rs1_data;
  word_t      rs2_data;
  logic       rf_we;
  reg_addr_t  rf_rd;
  word_t      rf_wdata;

  fetch_unit #(
    .RESET_PC(RESET_PC)
  ) u_fetch_unit (
    .clk            (clk),
    .rst            (rst),
    .retire_valid_i (retire_valid_o),
    .retire_i       (retire_o),
    .imem_addr_o    (imem_addr_o),
    .imem_data_i    (imem_data_i),
    .valid_o        (f_valid),
    .ready_i        (f_ready),
    .pkt_o          (f_pkt),
    .halted_o       (halted_o)
  );

  decode_unit u_decode_unit (
    .clk        (clk),
    .rst        (rst),
    .valid_i    (f_valid),
    .ready_o    (f_ready),
    .pkt_i      (f_pkt),
    .rs1_o      (rs1),
    .rs2_o      (rs2),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .valid_o    (d_valid),
    .ready_i    (d_ready),
    .pkt_o      (d_pkt)
  );

  reg_file u_reg_file (
    .clk        (clk),
    .rst        (rst),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (rf_we),
    .rd_i       (rf_rd),
    .wdata_i    (rf_wdata)
  );

  exec_unit u_exec_unit (
    .clk     (clk),
    .rst     (rst),
    .valid_i (d_valid),
    .ready_o (d_ready),
    .pkt_i   (d_pkt),
    .valid_o (x_valid),
    .ready_i (x_ready),
    .pkt_o   (x_pkt)
  );

  mem_stage #(
    .DMEM_WORDS(DMEM_WORDS)
  ) u_mem_stage (
    .clk            (clk),
    .rst            (rst),
    .valid_i        (x_valid),
    .ready_o        (x_ready),
    .pkt_i          (x_pkt),
    .rf_we_o        (rf_we),
    .rf_rd_o        (rf_rd),
    .rf_wdata_o     (rf_wdata),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

endmodule

`default_nettype wire

/* logic/mem_stage.sv */
`default_nettype none

module mem_stage #(
  parameter int DMEM_WORDS = 256
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                valid_i,
  output logic                ready_o,
  input  core_pkg::exe_pkt_t  pkt_i,
  output logic                rf_we_o,
  output core_pkg::reg_addr_t rf_rd_o,
  output core_pkg::word_t     rf_wdata_o,
  output logic                retire_valid_o,
  output core_pkg::retire_t   retire_o
);
  import core_pkg::*;

  localparam int AW = $clog2(DMEM_WORDS);

  word_t          dmem [DMEM_WORDS];
  exe_pkt_t       m;
  word_t          rdata_q;
  word_t          store_word;
  word_t          lane;
  word_t          load_data;
  word_t          wdata;
  logic [3:0]     be;
  logic [AW-1:0]  idx;
  logic           accept;

  assign accept     = valid_i && ready_o;
  assign idx        = pkt_i.mem_addr[AW+1:2];
  assign store_word = pkt_i.store_data << {pkt_i.mem_addr[1:0], 3'b000};

  always_comb begin
    case (pkt_i.funct3[1:0])
      2'b00:   be = 4'b0001 << pkt_i.mem_addr[1:0];
      2'b01:   be = 4'b0011 << pkt_i.mem_addr[1:0];
      default: be = 4'b1111;
    endcase
  end

  // Retire the cycle after accept
  always_ff @(posedge clk) begin
    if (rst) begin
      ready_o        <= 1'b1;
      retire_valid_o <= 1'b0;
    end else begin
      ready_o        <= !accept;
      retire_valid_o <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      m <= pkt_i;
      if (pkt_i.ren) begin
        rdata_q <= dmem[idx];
      end
      if (pkt_i.wen) begin
        for (int b = 0; b < 4; b++) begin
          if (be[b]) begin
            dmem[idx][8*b +: 8] <= store_word[8*b +: 8];
          end
        end
      end
    end
  end

  assign lane = rdata_q >> {m.mem_addr[1:0], 3'b000};

  always_comb begin
    case (m.funct3)
      3'b000:  load_data = {{24{lane[7]}}, lane[7:0]};
      3'b001:  load_data = {{16{lane[15]}}, lane[15:0]};
      3'b100:  load_data = {24'b0, lane[7:0]};
      3'b101:  load_data = {16'b0, lane[15:0]};
      default: load_data = lane;
    endcase
  end

  assign wdata      = m.ren ? load_data : m.result;
  assign rf_we_o    = retire_valid_o && m.rwen && !m.illegal;
  assign rf_rd_o    = m.rd;
  assign rf_wdata_o = wdata;

  always_comb begin
    retire_o.pc      = m.pc;
    retire_o.next_pc = m.next_pc;
    retire_o.rd      = m.rd;
    retire_o.data    = m.rwen ? wdata : '0;
    retire_o.rwen    = m.rwen;
    retire_o.illegal = m.illegal;
  end

endmodule

`default_nettype wire

/* logic/exec_unit.sv */
`default_nettype none

module exec_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               valid_i,
  output logic               ready_o,
  input  core_pkg::dec_pkt_t pkt_i,
  output logic               valid_o,
  input  logic               ready_i,
  output core_pkg::exe_pkt_t pkt_o
);
  import core_pkg::*;

  typedef enum logic {
    X_IDLE,
    X_WAIT_READY
  } exec_state_e;

  exec_state_e state;
  dec_pkt_t    d;
  word_t       alu_out;
  word_t       target;
  logic [4:0]  shamt;
  logic        cmp;
  logic        taken;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= X_IDLE;
      valid_o <= 1'b0;
      ready_o <= 1'b1;
    end else if (state == X_IDLE) begin
      if (valid_i) begin
        valid_o <= 1'b1;
        ready_o <= 1'b0;
        state   <= X_WAIT_READY;
      end
    end else if (ready_i) begin
      valid_o <= 1'b0;
      ready_o <= 1'b1;
      state   <= X_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      d <= pkt_i;
    end
  end

  assign shamt = d.op2[4:0];

  always_comb begin
    case (d.alu_op)
      ALU_ADD:  alu_out = d.op1 + d.op2;
      ALU_SUB:  alu_out = d.op1 - d.op2;
      ALU_SLL:  alu_out = d.op1 << shamt;
      ALU_SLT:  alu_out = {31'b0, $signed(d.op1) < $signed(d.op2)};
      ALU_SLTU: alu_out = {31'b0, d.op1 < d.op2};
      ALU_XOR:  alu_out = d.op1 ^ d.op2;
      ALU_SRL:  alu_out = d.op1 >> shamt;
      ALU_SRA:  alu_out = $signed(d.op1) >>> shamt;
      ALU_OR:   alu_out = d.op1 | d.op2;
      ALU_AND:  alu_out = d.op1 & d.op2;
      default:  alu_out = '0;
    endcase
  end

  // Branch compare on funct3
  always_comb begin
    case (d.funct3)
      3'b000:  cmp = (d.op1 == d.op2);
      3'b001:  cmp = (d.op1 != d.op2);
      3'b100:  cmp = ($signed(d.op1) < $signed(d.op2));
      3'b101:  cmp = ($signed(d.op1) >= $signed(d.op2));
      3'b110:  cmp = (d.op1 < d.op2);
      3'b111:  cmp = (d.op1 >= d.op2);
      default: cmp = 1'b0;
    endcase
  end

  assign taken  = d.en_j && (!d.branch || cmp);
  assign target = (d.op_j + d.imm) & ~32'd1; // JALR clears bit 0

  always_comb begin
    pkt_o            = '0;
    pkt_o.pc         = d.pc;
    pkt_o.result     = alu_out;
    pkt_o.next_pc    = taken ? target : d.pc + 32'd4;
    pkt_o.mem_addr   = d.op1 + d.imm;
    pkt_o.store_data = d.store_data;
    pkt_o.funct3     = d.funct3;
    pkt_o.rd         = d.rd;
    pkt_o.rwen       = d.rwen;
    pkt_o.ren        = d.ren;
    pkt_o.wen        = d.wen;
    pkt_o.illegal    = d.illegal;
  end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`default_nettype none

module reg_file (
  input  logic                clk,
  input  logic                rst,
  input  core_pkg::reg_addr_t rs1_i,
  input  core_pkg::reg_addr_t rs2_i,
  output core_pkg::word_t     rs1_data_o,
  output core_pkg::word_t     rs2_data_o,
  input  logic                we_i,
  input  core_pkg::reg_addr_t rd_i,
  input  core_pkg::word_t     wdata_i
);
  import core_pkg::*;

  word_t regs [1:31]; // No storage for x0

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_i != '0)) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

/* logic/decode_unit.sv */
`default_nettype none

module decode_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 valid_i,
  output logic                 ready_o,
  input  core_pkg::fetch_pkt_t pkt_i,
  output core_pkg::reg_addr_t  rs1_o,
  output core_pkg::reg_addr_t  rs2_o,
  input  core_pkg::word_t      rs1_data_i,
  input  core_pkg::word_t      rs2_data_i,
  output logic                 valid_o,
  input  logic                 ready_i,
  output core_pkg::dec_pkt_t   pkt_o
);
  import core_pkg::*;

  typedef enum logic {
    D_IDLE,
    D_WAIT_READY
  } dec_state_e;

  dec_state_e state;
  inst_t      inst_q;
  word_t      pc_q;
  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode = opcode_e'(inst_q[6:0]);
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];
  assign rd     = inst_q[11:7];
  assign rs1_o  = inst_q[19:15];
  assign rs2_o  = inst_q[24:20];

  assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_s = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
  assign imm_b = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
  assign imm_u = {inst_q[31:12], 12'b0};
  assign imm_j = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

  // ######################################
  // Handshake
  // ######################################

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= D_IDLE;
      valid_o <= 1'b0;
      ready_o <= 1'b1;
    end else begin
      case (state)
        D_IDLE: begin
          if (valid_i) begin
            valid_o <= 1'b1;
            ready_o <= 1'b0;
            state   <= D_WAIT_READY;
          end
        end
        default: begin
          if (ready_i) begin
            valid_o <= 1'b0;
            ready_o <= 1'b1;
            state   <= D_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      inst_q <= pkt_i.inst;
      pc_q   <= pkt_i.pc;
    end
  end

  // ######################################
  // Field decode
  // ######################################

  always_comb begin
    pkt_o        = '0;
    pkt_o.pc     = pc_q;
    pkt_o.funct3 = funct3;
    pkt_o.alu_op = ALU_ADD;
    case (opcode)
      OPC_LUI: begin
        pkt_o.op2  = imm_u; // op1 stays zero
        pkt_o.imm  = imm_u;
        pkt_o.rd   = rd;
        pkt_o.rwen = 1'b1;
      end
      OPC_AUIPC: begin
        pkt_o.op1  = pc_q;
        pkt_o.op2  = imm_u;
        pkt_o.imm  = imm_u;
        pkt_o.rd   = rd;
        pkt_o.rwen = 1'b1;
      end
      OPC_JAL: begin
        pkt_o.op1  = pc_q; // Link address pc + 4
        pkt_o.op2  = 32'd4;
        pkt_o.op_j = pc_q;
        pkt_o.imm  = imm_j;
        pkt_o.rd   = rd;
        pkt_o.rwen = 1'b1;
        pkt_o.en_j = 1'b1;
      end
      OPC_JALR: begin
        pkt_o.op1  = pc_q;
        pkt_o.op2  = 32'd4;
        pkt_o.op_j = rs1_data_i;
        pkt_o.imm  = imm_i;
        pkt_o.rd   = rd;
        pkt_o.rwen = 1'b1;
        pkt_o.en_j = 1'b1;
      end
      OPC_BRANCH: begin
        pkt_o.op1    = rs1_data_i;
        pkt_o.op2    = rs2_data_i;
        pkt_o.op_j   = pc_q;
        pkt_o.imm    = imm_b;
        pkt_o.en_j   = 1'b1;
        pkt_o.branch = 1'b1;
      end
      OPC_LOAD: begin
        pkt_o.op1  = rs1_data_i;
        pkt_o.op2  = imm_i;
        pkt_o.imm  = imm_i;
        pkt_o.rd   = rd;
        pkt_o.rwen = 1'b1;
        pkt_o.ren  = 1'b1;
      end
      OPC_STORE: begin
        pkt_o.op1        = rs1_data_i;
        pkt_o.op2        = imm_s;
        pkt_o.imm        = imm_s;
        pkt_o.store_data = rs2_data_i;
        pkt_o.wen        = 1'b1;
      end
      OPC_OP_IMM: begin
        pkt_o.op1    = rs1_data_i;
        pkt_o.op2    = imm_i;
        pkt_o.imm    = imm_i;
        pkt_o.alu_op = alu_op_e'({(funct3 == 3'b101) ? funct7[5] : 1'b0, funct3}); // SRAI
        pkt_o.rd     = rd;
        pkt_o.rwen   = 1'b1;
      end
      OPC_OP: begin
        pkt_o.op1    = rs1_data_i;
        pkt_o.op2    = rs2_data_i;
        pkt_o.alu_op = alu_op_e'({funct7[5], funct3});
        pkt_o.rd     = rd;
        pkt_o.rwen   = 1'b1;
      end
      OPC_FENCE: begin
      end
      default: begin
        pkt_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

/* logic/fetch_unit.sv */
`default_nettype none

module fetch_unit #(
  parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 retire_valid_i,
  input  core_pkg::retire_t    retire_i,
  output core_pkg::word_t      imem_addr_o,
  input  core_pkg::inst_t      imem_data_i,
  output logic                 valid_o,
  input  logic                 ready_i,
  output core_pkg::fetch_pkt_t pkt_o,
  output logic                 halted_o
);
  import core_pkg::*;

  typedef enum logic [1:0] {
    F_ISSUE,
    F_WAIT,
    F_HALT
  } fetch_state_e;

  fetch_state_e state;
  word_t        pc;
  logic         restart;
  logic         load;

  assign restart     = (state == F_WAIT) && retire_valid_i && !retire_i.illegal;
  assign load        = ((state == F_ISSUE) && !valid_o) || restart;
  assign imem_addr_o = restart ? retire_i.next_pc : pc; // Bypass retired PC

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= F_ISSUE;
      pc       <= RESET_PC;
      valid_o  <= 1'b0;
      halted_o <= 1'b0;
    end else begin
      case (state)
        F_ISSUE: begin
          if (!valid_o) begin
            valid_o <= 1'b1;
          end else if (ready_i) begin
            valid_o <= 1'b0;
            state   <= F_WAIT;
          end
        end
        F_WAIT: begin
          if (retire_valid_i) begin
            if (retire_i.illegal) begin
              halted_o <= 1'b1;
              state    <= F_HALT;
            end else begin
              pc      <= retire_i.next_pc;
              valid_o <= 1'b1;
              state   <= F_ISSUE;
            end
          end
        end
        default: begin
          state <= F_HALT; // Only reset leaves
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      pkt_o.pc   <= imem_addr_o;
      pkt_o.inst <= imem_data_i;
    end
  end

endmodule

`default_nettype wire

/* logic/core_pkg.sv */
`default_nettype none

package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;

  // ######################################
  // Encodings
  // ######################################

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_FENCE  = 7'b0001111
  } opcode_e;

  // Same bits as {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  // ######################################
  // Stage packets
  // ######################################

  typedef struct packed {
    word_t pc;
    inst_t inst;
  } fetch_pkt_t;

  typedef struct packed {
    word_t      pc;
    word_t      op1;
    word_t      op2;
    word_t      op_j;        // Jump base
    word_t      imm;
    word_t      store_data;
    alu_op_e    alu_op;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic       rwen;
    logic       en_j;
    logic       ren;
    logic       wen;
    logic       branch;
    logic       illegal;
  } dec_pkt_t;

  typedef struct packed {
    word_t      pc;
    word_t      result;
    word_t      next_pc;
    word_t      mem_addr;
    word_t      store_data;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic       rwen;
    logic       ren;
    logic       wen;
    logic       illegal;
  } exe_pkt_t;

  typedef struct packed {
    word_t     pc;
    word_t     next_pc;
    reg_addr_t rd;
    word_t     data;
    logic      rwen;
    logic      illegal;
  } retire_t;

endpackage

`default_nettype wire
